// ==== design/cpu_types_pkg.sv ====
package cpu_types_pkg;

    // data and instruction width.
    parameter int WORD_W = 32;

    // index into the 32 registers.
    typedef logic [4:0] reg_idx_t;

    // **************************************************************************
    // instruction encodings
    // **************************************************************************

    // primary opcode in instr[31:26].
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_HALT  = 6'h3f
    } opcode_t;

    // r-type function field in instr[5:0].
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    // **************************************************************************
    // alu operations
    // **************************************************************************

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLT = 4'h5,  // signed compare.
        ALU_SLL = 4'h6,  // rt shifted by shamt.
        ALU_LUI = 4'h7   // immediate into the upper half.
    } alu_op_t;

endpackage

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage
    import cpu_types_pkg::*;
(
    input  logic [WORD_W-1:0] instr,
    output reg_idx_t          rs,
    output reg_idx_t          rt,
    output reg_idx_t          rd,
    output alu_op_t           alu_op,
    output logic              alu_src_imm,
    output logic              reg_wr,
    output reg_idx_t          dest,
    output logic [WORD_W-1:0] imm,
    output logic [4:0]        shamt,
    output logic              beq,
    output logic              bne,
    output logic              halt,
    output logic              illegal
);

    opcode_t     opcode;
    funct_t      funct;
    logic [15:0] imm16;
    logic        writes;
    logic        zero_ext;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign imm16  = instr[15:0];

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        writes      = 1'b0;
        dest        = rt;       // i-type default.
        zero_ext    = 1'b0;
        beq         = 1'b0;
        bne         = 1'b0;
        halt        = 1'b0;
        illegal     = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                dest   = rd;
                writes = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    default: begin
                        writes  = 1'b0;
                        illegal = 1'b1;
                    end
                endcase
            end
            OP_ADDIU: begin
                alu_src_imm = 1'b1;
                writes      = 1'b1;
            end
            OP_ANDI: begin
                alu_op      = ALU_AND;
                alu_src_imm = 1'b1;
                writes      = 1'b1;
                zero_ext    = 1'b1;
            end
            OP_ORI: begin
                alu_op      = ALU_OR;
                alu_src_imm = 1'b1;
                writes      = 1'b1;
                zero_ext    = 1'b1;
            end
            OP_LUI: begin
                alu_op      = ALU_LUI;
                alu_src_imm = 1'b1;
                writes      = 1'b1;
            end
            OP_BEQ: begin
                alu_op = ALU_SUB;   // value unused, only the compare counts.
                beq    = 1'b1;
            end
            OP_BNE: begin
                alu_op = ALU_SUB;
                bne    = 1'b1;
            end
            OP_HALT: halt = 1'b1;
            default: illegal = 1'b1;
        endcase
    end

    assign imm = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    // a write to register zero is dropped here.
    assign reg_wr = writes && (dest != '0);

endmodule

// ==== design/exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage
    import cpu_types_pkg::*;
(
    input  logic              valid,
    input  reg_idx_t          rs,
    input  reg_idx_t          rt,
    input  logic [WORD_W-1:0] rdat1,
    input  logic [WORD_W-1:0] rdat2,
    input  alu_op_t           alu_op,
    input  logic              alu_src_imm,
    input  logic [WORD_W-1:0] imm,
    input  logic [4:0]        shamt,
    input  logic              beq,
    input  logic              bne,
    input  logic              fwd_valid,
    input  logic              fwd_wen,
    input  reg_idx_t          fwd_dest,
    input  logic [WORD_W-1:0] fwd_value,
    output logic [WORD_W-1:0] value,
    output logic              taken
);

    logic              fwd_ok;
    logic              fwd_a;
    logic              fwd_b;
    logic [WORD_W-1:0] op_a;
    logic [WORD_W-1:0] op_b;
    logic [WORD_W-1:0] alu_b;
    logic              equal;

    // **************************************************************************
    // operand forwarding from the result register
    // **************************************************************************

    assign fwd_ok = fwd_valid && fwd_wen && (fwd_dest != '0);
    assign fwd_a  = fwd_ok && (fwd_dest == rs);
    assign fwd_b  = fwd_ok && (fwd_dest == rt);

    assign op_a = fwd_a ? fwd_value : rdat1;
    assign op_b = fwd_b ? fwd_value : rdat2;

    assign alu_b = alu_src_imm ? imm : op_b;

    // **************************************************************************
    // alu
    // **************************************************************************

    always_comb begin
        case (alu_op)
            ALU_ADD: value = op_a + alu_b;
            ALU_SUB: value = op_a - alu_b;
            ALU_AND: value = op_a & alu_b;
            ALU_OR:  value = op_a | alu_b;
            ALU_XOR: value = op_a ^ alu_b;
            ALU_SLT: begin
                value = {{(WORD_W-1){1'b0}}, ($signed(op_a) < $signed(alu_b))};
            end
            ALU_SLL: value = op_b << shamt;         // rt by shamt.
            ALU_LUI: value = {imm[15:0], 16'h0000};
            default: value = '0;
        endcase
    end

    // branch compare always on the two register operands.
    assign equal = (op_a == op_b);
    assign taken = valid && ((beq && equal) || (bne && !equal));

endmodule

// ==== design/idecode_iexec.sv ====
`timescale 1ns/100ps

module idecode_iexec
    import cpu_types_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic              stall,
    input  logic              load,
    input  reg_idx_t          rs_in,
    input  reg_idx_t          rt_in,
    input  reg_idx_t          rd_in,
    input  alu_op_t           alu_op_in,
    input  logic              alu_src_imm_in,
    input  logic              reg_wr_in,
    input  reg_idx_t          dest_in,
    input  logic [WORD_W-1:0] imm_in,
    input  logic [4:0]        shamt_in,
    input  logic              beq_in,
    input  logic              bne_in,
    input  logic              halt_in,
    input  logic              illegal_in,
    input  logic [WORD_W-1:0] rdat1_in,
    input  logic [WORD_W-1:0] rdat2_in,
    output reg_idx_t          rs_out,
    output reg_idx_t          rt_out,
    output reg_idx_t          rd_out,
    output alu_op_t           alu_op_out,
    output logic              alu_src_imm_out,
    output logic              reg_wr_out,
    output reg_idx_t          dest_out,
    output logic [WORD_W-1:0] imm_out,
    output logic [4:0]        shamt_out,
    output logic              beq_out,
    output logic              bne_out,
    output logic              halt_out,
    output logic              illegal_out,
    output logic [WORD_W-1:0] rdat1_out,
    output logic [WORD_W-1:0] rdat2_out,
    output logic              valid_out
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            {rs_out, rt_out, rd_out, dest_out, shamt_out} <= '0;
            alu_op_out      <= ALU_ADD;
            alu_src_imm_out <= 1'b0;
            imm_out         <= '0;
            rdat1_out       <= '0;
            rdat2_out       <= '0;
            {valid_out, reg_wr_out, beq_out, bne_out, halt_out, illegal_out} <= '0;
        end else if (!stall) begin
            rs_out          <= rs_in;
            rt_out          <= rt_in;
            rd_out          <= rd_in;
            dest_out        <= dest_in;
            shamt_out       <= shamt_in;
            alu_op_out      <= alu_op_in;
            alu_src_imm_out <= alu_src_imm_in;
            imm_out         <= imm_in;
            rdat1_out       <= rdat1_in;
            rdat2_out       <= rdat2_in;
            // without load the enables drop and a bubble goes in.
            valid_out   <= load;
            reg_wr_out  <= load && reg_wr_in;
            beq_out     <= load && beq_in;
            bne_out     <= load && bne_in;
            halt_out    <= load && halt_in;
            illegal_out <= load && illegal_in;
        end
    end

    hold_on_stall: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> $stable({valid_out, rs_out, rt_out, rd_out, dest_out, alu_op_out,
                           reg_wr_out, imm_out, rdat1_out, rdat2_out, beq_out, bne_out,
                           halt_out}));

    write_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
        reg_wr_out |-> valid_out);

endmodule

// ==== design/pipeline_top.sv ====
`timescale 1ns/100ps

module pipeline_top
    import cpu_types_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic [WORD_W-1:0] instr,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  logic              res_ready,
    output logic              res_valid,
    output reg_idx_t          res_dest,
    output logic [WORD_W-1:0] res_value,
    output logic              res_wen,
    output logic              res_branch,
    output logic              halted
);

    logic stall, load, halt_seen;
    reg_idx_t dec_rs, dec_rt, dec_rd, dec_dest, ex_rs, ex_rt, ex_rd, ex_dest;
    alu_op_t dec_alu_op, ex_alu_op;
    logic [WORD_W-1:0] dec_imm, ex_imm, rdat1, rdat2, ex_rdat1, ex_rdat2, ex_value;
    logic [4:0] dec_shamt, ex_shamt;
    logic dec_src_imm, dec_reg_wr, dec_beq, dec_bne, dec_halt, dec_illegal;
    logic ex_src_imm, ex_reg_wr, ex_beq, ex_bne, ex_halt, ex_illegal, ex_valid, ex_taken;

    // result held and not taken freezes everything behind it.
    assign stall       = res_valid && !res_ready;
    assign instr_ready = !stall && !halt_seen;
    assign load        = instr_valid && instr_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)                 halt_seen <= 1'b0;
        else if (load && dec_halt) halt_seen <= 1'b1;  // no fetch past halt.
    end

    register_file rf_i (.CLK, .nRST, .rs_addr(dec_rs), .rt_addr(dec_rt),
        .wen(res_valid && res_ready && res_wen), .waddr(res_dest), .wdata(res_value),
        .rs_data(rdat1), .rt_data(rdat2));

    decode_stage dec_i (.instr, .rs(dec_rs), .rt(dec_rt), .rd(dec_rd), .alu_op(dec_alu_op),
        .alu_src_imm(dec_src_imm), .reg_wr(dec_reg_wr), .dest(dec_dest), .imm(dec_imm),
        .shamt(dec_shamt), .beq(dec_beq), .bne(dec_bne), .halt(dec_halt),
        .illegal(dec_illegal));

    idecode_iexec idex_i (.CLK, .nRST, .stall, .load, .rs_in(dec_rs), .rt_in(dec_rt),
        .rd_in(dec_rd), .alu_op_in(dec_alu_op), .alu_src_imm_in(dec_src_imm),
        .reg_wr_in(dec_reg_wr), .dest_in(dec_dest), .imm_in(dec_imm), .shamt_in(dec_shamt),
        .beq_in(dec_beq), .bne_in(dec_bne), .halt_in(dec_halt), .illegal_in(dec_illegal),
        .rdat1_in(rdat1), .rdat2_in(rdat2), .rs_out(ex_rs), .rt_out(ex_rt), .rd_out(ex_rd),
        .alu_op_out(ex_alu_op), .alu_src_imm_out(ex_src_imm), .reg_wr_out(ex_reg_wr),
        .dest_out(ex_dest), .imm_out(ex_imm), .shamt_out(ex_shamt), .beq_out(ex_beq),
        .bne_out(ex_bne), .halt_out(ex_halt), .illegal_out(ex_illegal),
        .rdat1_out(ex_rdat1), .rdat2_out(ex_rdat2), .valid_out(ex_valid));

    exec_stage ex_i (.valid(ex_valid), .rs(ex_rs), .rt(ex_rt), .rdat1(ex_rdat1),
        .rdat2(ex_rdat2), .alu_op(ex_alu_op), .alu_src_imm(ex_src_imm), .imm(ex_imm),
        .shamt(ex_shamt), .beq(ex_beq), .bne(ex_bne), .fwd_valid(res_valid),
        .fwd_wen(res_wen), .fwd_dest(res_dest), .fwd_value(res_value),
        .value(ex_value), .taken(ex_taken));

    result_stage res_i (.CLK, .nRST, .stall, .valid_in(ex_valid), .wen_in(ex_reg_wr),
        .dest_in(ex_dest), .value_in(ex_value), .branch_in(ex_taken), .halt_in(ex_halt),
        .res_valid, .res_wen, .res_dest, .res_value, .res_branch, .halted);

    // a write in execute comes from a legal decode with rd or rt as its target.
    legal_write_dest: assert property (@(posedge CLK) disable iff (!nRST)
        ex_reg_wr |-> !ex_illegal && (ex_dest == (ex_src_imm ? ex_rt : ex_rd)));

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/100ps

module register_file
    import cpu_types_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  reg_idx_t          rs_addr,
    input  reg_idx_t          rt_addr,
    input  logic              wen,
    input  reg_idx_t          waddr,
    input  logic [WORD_W-1:0] wdata,
    output logic [WORD_W-1:0] rs_data,
    output logic [WORD_W-1:0] rt_data
);

    logic [WORD_W-1:0] regs [32];
    logic              wr_en;

    assign wr_en = wen && (waddr != '0);  // register zero never written.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so a decode in the write-back cycle sees the new value.
    always_comb begin
        rs_data = (wr_en && waddr == rs_addr) ? wdata : regs[rs_addr];
        rt_data = (wr_en && waddr == rt_addr) ? wdata : regs[rt_addr];
    end

    zero_reg_reads_zero: assert property (@(posedge CLK) disable iff (!nRST)
        (rs_addr != '0 || rs_data == '0) && (rt_addr != '0 || rt_data == '0));

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/100ps

module result_stage
    import cpu_types_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic              stall,
    input  logic              valid_in,
    input  logic              wen_in,
    input  reg_idx_t          dest_in,
    input  logic [WORD_W-1:0] value_in,
    input  logic              branch_in,
    input  logic              halt_in,
    output logic              res_valid,
    output logic              res_wen,
    output reg_idx_t          res_dest,
    output logic [WORD_W-1:0] res_value,
    output logic              res_branch,
    output logic              halted
);

    // control.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            res_valid  <= 1'b0;
            res_wen    <= 1'b0;
            res_branch <= 1'b0;
            halted     <= 1'b0;
        end else if (!stall) begin
            res_valid  <= valid_in;
            res_wen    <= valid_in && wen_in;
            res_branch <= valid_in && branch_in;
            if (valid_in && halt_in) begin
                halted <= 1'b1;  // sticky until reset.
            end
        end
    end

    // payload.
    always_ff @(posedge CLK) begin
        if (!stall) begin
            res_dest  <= dest_in;
            res_value <= value_in;
        end
    end

    no_zero_write: assert property (@(posedge CLK) disable iff (!nRST)
        res_wen |-> (res_dest != '0));

endmodule

// ==== sources.f ====
design/cpu_types_pkg.sv
design/register_file.sv
design/decode_stage.sv
design/idecode_iexec.sv
design/exec_stage.sv
design/result_stage.sv
design/pipeline_top.sv
tests/pipeline_tb.sv

// ==== tests/pipeline_tb.sv ====
`timescale 1ns/100ps

module pipeline_tb
    import cpu_types_pkg::*;
();

    localparam int WAIT_LIMIT = 200;  // cycles before any wait gives up.

    logic              CLK;
    logic              nRST;
    logic [WORD_W-1:0] instr;
    logic              instr_valid;
    logic              instr_ready;
    logic              res_ready;
    logic              res_valid;
    reg_idx_t          res_dest;
    logic [WORD_W-1:0] res_value;
    logic              res_wen;
    logic              res_branch;
    logic              halted;

    // one queue entry of the reference model is {halt, branch, wen, dest, value}.
    logic [WORD_W-1:0] model_regs [32];
    logic [39:0]       exp_q [$];
    logic              exp_valid  = 1'b0;
    logic              exp_halt   = 1'b0;
    logic              exp_branch = 1'b0;
    logic              exp_wen    = 1'b0;
    reg_idx_t          exp_dest   = '0;
    logic [WORD_W-1:0] exp_value  = '0;
    logic              halt_sent  = 1'b0;

    logic random_ready = 1'b0;
    logic timed_out    = 1'b0;
    int   error_count  = 0;
    int   results_seen = 0;
    int   tests_done   = 0;

    pipeline_top dut_i (.CLK, .nRST, .instr, .instr_valid, .instr_ready, .res_ready,
        .res_valid, .res_dest, .res_value, .res_wen, .res_branch, .halted);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // **************************************************************************
    // reference model
    // **************************************************************************

    function automatic logic [39:0] expected_result(input logic [WORD_W-1:0] w);
        logic [WORD_W-1:0] a, b, sx, zx, v;
        reg_idx_t          dest;
        logic              wen, br, hlt;
        a    = model_regs[w[25:21]];
        b    = model_regs[w[20:16]];
        sx   = {{16{w[15]}}, w[15:0]};
        zx   = {16'h0000, w[15:0]};
        v    = '0;
        dest = w[20:16];
        wen  = 1'b1;
        br   = 1'b0;
        hlt  = 1'b0;
        case (w[31:26])
            OP_RTYPE: begin
                dest = w[15:11];
                case (w[5:0])
                    FN_ADDU: v = a + b;
                    FN_SUBU: v = a - b;
                    FN_AND:  v = a & b;
                    FN_OR:   v = a | b;
                    FN_XOR:  v = a ^ b;
                    FN_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  v = b << w[10:6];
                    default: wen = 1'b0;
                endcase
            end
            OP_ADDIU: v = a + sx;
            OP_ANDI:  v = a & zx;
            OP_ORI:   v = a | zx;
            OP_LUI:   v = {w[15:0], 16'h0000};
            OP_BEQ: begin
                wen = 1'b0;
                br  = (a == b);
            end
            OP_BNE: begin
                wen = 1'b0;
                br  = (a != b);
            end
            OP_HALT: begin
                wen = 1'b0;
                hlt = 1'b1;
            end
            default: wen = 1'b0;
        endcase
        if (dest == '0) wen = 1'b0;  // register zero stays zero.
        return {hlt, br, wen, dest, v};
    endfunction

    // retire on the output handshake and predict on acceptance.
    always @(posedge CLK or negedge nRST) begin
        logic [39:0] entry;
        if (!nRST) begin
            for (int i = 0; i < 32; i++) model_regs[i] = '0;
            exp_q.delete();
            halt_sent = 1'b0;
        end else begin
            if (res_valid && res_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                results_seen++;
            end
            if (instr_valid && instr_ready) begin
                entry = expected_result(instr);
                if (entry[37]) model_regs[entry[36:32]] = entry[31:0];
                if (entry[39]) halt_sent = 1'b1;
                exp_q.push_back(entry);
            end
        end
        exp_valid = (exp_q.size() > 0);
        if (exp_valid) {exp_halt, exp_branch, exp_wen, exp_dest, exp_value} = exp_q[0];
    end

    // **************************************************************************
    // checks
    // **************************************************************************

    task automatic report_mismatch(input string name, input logic [WORD_W-1:0] want,
                                   input logic [WORD_W-1:0] got);
        $display("ERR %0t %s expected %h got %h", $time, name, want, got);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("at %0t: %s", $time, what);
        error_count++;
    endtask

    reset_state_ok: assert property (@(posedge CLK)
        $rose(nRST) |-> !res_valid && !res_wen && !halted && instr_ready)
        else report_failure("outputs were not in their reset state after reset");

    result_expected: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid && res_ready |-> exp_valid)
        else report_failure("a result came out when none was expected");

    wen_ok: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid && res_ready && exp_valid |-> res_wen == exp_wen)
        else report_mismatch("res_wen", $sampled(exp_wen), $sampled(res_wen));

    dest_ok: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid && res_ready && exp_valid && exp_wen |-> res_dest == exp_dest)
        else report_mismatch("res_dest", $sampled(exp_dest), $sampled(res_dest));

    value_ok: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid && res_ready && exp_valid && exp_wen |-> res_value == exp_value)
        else report_mismatch("res_value", $sampled(exp_value), $sampled(res_value));

    branch_ok: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid && res_ready && exp_valid |-> res_branch == exp_branch)
        else report_mismatch("res_branch", $sampled(exp_branch), $sampled(res_branch));

    held_stable: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid && !res_ready |=> res_valid && $stable(res_value) && $stable(res_dest)
                                    && $stable(res_wen) && $stable(res_branch))
        else report_failure("a held result changed before it was taken");

    one_cycle_latency: assert property (@(posedge CLK) disable iff (!nRST)
        (instr_valid && instr_ready) ##1 !(res_valid && !res_ready) |=> res_valid)
        else report_failure("an accepted instruction did not reach the result register");

    halt_blocks_input: assert property (@(posedge CLK) disable iff (!nRST)
        halt_sent |-> !instr_ready)
        else report_failure("input was still ready after a halt was accepted");

    halted_sticky: assert property (@(posedge CLK) disable iff (!nRST)
        halted |=> halted)
        else report_failure("halted dropped before reset");

    halted_on_halt: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid && exp_valid |-> halted == exp_halt)
        else report_mismatch("halted", $sampled(exp_halt), $sampled(halted));

    // **************************************************************************
    // stimulus
    // **************************************************************************

    function automatic logic [WORD_W-1:0] r_word(input funct_t fn, input reg_idx_t rd,
        input reg_idx_t rs, input reg_idx_t rt, input logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [WORD_W-1:0] i_word(input opcode_t op, input reg_idx_t rt,
        input reg_idx_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [WORD_W-1:0] random_word(input int top_reg);
        funct_t  fns [7] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL};
        opcode_t ops [4] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI};
        reg_idx_t a, b, c;
        int       pick;
        a    = 5'($urandom_range(top_reg, 0));
        b    = 5'($urandom_range(top_reg, 0));
        c    = 5'($urandom_range(top_reg, 0));
        pick = $urandom_range(10, 0);
        if (pick < 7) return r_word(fns[pick], a, b, c, 5'($urandom));
        return i_word(ops[pick - 7], a, b, 16'($urandom));
    endfunction

    task automatic advance_cycle();
        @(negedge CLK);
        res_ready = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
    endtask

    task automatic send(input logic [WORD_W-1:0] word);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (timed_out) return;
        instr       = word;
        instr_valid = 1'b1;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge CLK);
            taken = instr_ready;
            advance_cycle();
            waited++;
        end
        instr_valid = 1'b0;
        if (!taken) begin
            $display("timeout: instruction %h not accepted in %0d cycles", word, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (!timed_out && exp_q.size() > 0) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout: %0d expected results never came out", exp_q.size());
                timed_out = 1'b1;
            end else begin
                advance_cycle();
                waited++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d %s: done, %0d errors so far", tests_done, name, error_count);
    endtask

    initial begin
        void'($urandom(32'h1c98));
        nRST        = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        res_ready   = 1'b0;
        repeat (3) @(negedge CLK);
        nRST      = 1'b1;
        res_ready = 1'b1;

        for (int r = 1; r < 32; r++) send(i_word(OP_ORI, 5'(r), 5'(r), 16'h0000));
        drain();
        finish_test("reset state");

        repeat (40) send(random_word(31));
        drain();
        finish_test("alu results");

        send(i_word(OP_ADDIU, 5'd5, 5'd0, 16'($urandom)));
        repeat (4) send(r_word(FN_ADDU, 5'd5, 5'd5, 5'd5, 5'd0));  // chain through $5.
        send(r_word(FN_SLL, 5'd6, 5'd0, 5'd5, 5'd3));
        send(i_word(OP_LUI, 5'd7, 5'd0, 16'($urandom)));
        send(i_word(OP_ORI, 5'd8, 5'd0, 16'($urandom)));
        send(r_word(FN_SUBU, 5'd9, 5'd7, 5'd6, 5'd0));  // $7 via write-through.
        send(r_word(FN_XOR, 5'd10, 5'd8, 5'd9, 5'd0));
        drain();
        finish_test("forwarding");

        random_ready = 1'b1;
        repeat (60) send(random_word(7));
        drain();
        random_ready = 1'b0;
        finish_test("back-pressure");

        send(i_word(OP_ADDIU, 5'd1, 5'd0, 16'h1234));
        send(i_word(OP_ORI, 5'd2, 5'd0, 16'h1234));
        send(i_word(OP_ADDIU, 5'd3, 5'd0, 16'h8001));
        send(i_word(OP_BEQ, 5'd2, 5'd1, 16'h0004));  // equal.
        send(i_word(OP_BNE, 5'd2, 5'd1, 16'h0004));
        send(i_word(OP_BEQ, 5'd3, 5'd1, 16'h0008));  // unequal.
        send(i_word(OP_BNE, 5'd3, 5'd1, 16'h0008));
        send(r_word(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
        send(i_word(OP_ADDIU, 5'd0, 5'd3, 16'h0001));
        drain();
        finish_test("branch compare");

        send({OP_HALT, 26'h0});
        instr       = i_word(OP_ADDIU, 5'd4, 5'd0, 16'h0001);
        instr_valid = 1'b1;
        repeat (8) advance_cycle();  // offered after the halt and never taken.
        instr_valid = 1'b0;
        drain();
        repeat (4) advance_cycle();
        finish_test("halt");

        $display("tests %0d, results checked %0d, errors %0d, timed out %0d",
                 tests_done, results_seen, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
